// ==== design/kbd_pkg.sv ====
/*
 * Shared widths, prefix bytes and enums for the PS/2 keyboard front end.
 * FIFO_DEPTH must stay a power of two so the FIFO pointers wrap cleanly.
 */

package kbd_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Keycode and FIFO sizing
   ////////////////////////////////////////////////////////////////////////////

   // Bit 8 is the break flag, bits 7:0 the translated code
   localparam int KEYCODE_W  = 9;
   localparam int FIFO_DEPTH = 8;

   // PS/2 set 2 prefix bytes
   localparam logic [7:0] CODE_E0 = 8'hE0;
   localparam logic [7:0] CODE_F0 = 8'hF0;

   ////////////////////////////////////////////////////////////////////////////
   // Enums
   ////////////////////////////////////////////////////////////////////////////

   // Prefix tracking states of the scancode converter
   typedef enum logic [2:0] {
      IDLE,
      E0,
      F0,
      E0F0,
      CONVERT_DOWN,
      CONVERT_UP,
      STROBE
   } conv_state_t;

   // APB register word offsets
   typedef enum logic [3:0] {
      REG_STATUS = 4'h0,
      REG_DATA   = 4'h4,
      REG_CTRL   = 4'h8
   } kbd_reg_t;

endpackage

// ==== design/ps2_rx.sv ====
/*
 * PS/2 device-to-host receiver. No bit timeout, so a glitch on ps2_clk can
 * leave the bit counter out of step until the next clean frame boundary.
 */

`timescale 1ns/10ps

module ps2_rx (
   input  logic       clk,
   input  logic       reset,
   input  logic       ps2_clk,
   input  logic       ps2_data,
   output logic       code_valid,
   output logic [7:0] code,
   output logic       frame_err
);

   logic [1:0] clk_sync;
   logic [1:0] data_sync;
   logic       clk_prev;
   logic       fall;
   logic [3:0] bit_cnt;
   logic [9:0] shift;
   logic       frame_done;
   logic       chk_valid;
   logic       chk_ok;
   logic [7:0] chk_data;

   // Two flop synchronizers, lines idle high
   always_ff @(posedge clk) begin
      if (reset) begin
         clk_sync  <= 2'b11;
         data_sync <= 2'b11;
         clk_prev  <= 1'b1;
      end else begin
         clk_sync  <= {clk_sync[0], ps2_clk};
         data_sync <= {data_sync[0], ps2_data};
         clk_prev  <= clk_sync[1];
      end
   end

   // Keyboard clock falling edge, data is stable here
   assign fall = clk_prev & ~clk_sync[1];

   // Bit counter
   // 0 waits for a low start bit, 1..10 take data, parity and stop
   always_ff @(posedge clk) begin
      if (reset) begin
         bit_cnt    <= 4'd0;
         frame_done <= 1'b0;
      end else begin
         frame_done <= 1'b0;
         if (fall) begin
            if (bit_cnt == 4'd0) begin
               if (!data_sync[1])
                  bit_cnt <= 4'd1;
            end else if (bit_cnt == 4'd10) begin
               bit_cnt    <= 4'd0;
               frame_done <= 1'b1;
            end else begin
               bit_cnt <= bit_cnt + 4'd1;
            end
         end
      end
   end

   // LSB arrives first, so shift in from the top
   // After stop: [9] stop, [8] parity, [7:0] data
   always_ff @(posedge clk) begin
      if (fall && bit_cnt != 4'd0)
         shift <= {data_sync[1], shift[9:1]};
   end

   // Check stage
   // Odd parity over data plus parity bit, stop must be high
   always_ff @(posedge clk) begin
      if (reset)
         chk_valid <= 1'b0;
      else
         chk_valid <= frame_done;
   end

   always_ff @(posedge clk) begin
      if (frame_done) begin
         chk_data <= shift[7:0];
         chk_ok   <= (^shift[8:0]) & shift[9];
      end
   end

   // Output stage, one pulse per frame
   always_ff @(posedge clk) begin
      if (reset) begin
         code_valid <= 1'b0;
         frame_err  <= 1'b0;
      end else begin
         code_valid <= chk_valid & chk_ok;
         frame_err  <= chk_valid & ~chk_ok;
      end
   end

   // Byte only updates on a good frame
   always_ff @(posedge clk) begin
      if (chk_valid && chk_ok)
         code <= chk_data;
   end

   a_valid_err_excl: assert property (@(posedge clk) disable iff (reset)
      !(code_valid && frame_err));

endmodule

// ==== design/scancode_rom.sv ====
/*
 * Small fixed PS/2 set 2 to Space Cadet table. Address bit 8 is the E0 flag.
 * Anything not listed returns 0 and is dropped by the converter.
 */

`timescale 1ns/10ps

module scancode_rom (
   input  logic [8:0] addr,
   output logic [7:0] data
);

   ////////////////////////////////////////////////////////////////////////////
   // Translation table
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (addr)
         // Plain keys
         9'h01C: begin
            // A
            data = 8'h23;
         end
         9'h032: begin
            // B
            data = 8'h3C;
         end
         9'h05A: begin
            // Enter maps to Return
            data = 8'h36;
         end
         9'h029: begin
            // Space
            data = 8'h13;
         end

         // Extended keys
         9'h175: begin
            // Up arrow
            data = 8'h6B;
         end
         9'h172: begin
            // Down arrow
            data = 8'h6C;
         end
         9'h114: begin
            // Right control
            data = 8'h7A;
         end

         // Unmapped
         default: begin
            data = 8'h00;
         end
      endcase
   end

endmodule

// ==== design/scancode_convert.sv ====
/*
 * Prefix state machine for E0 and F0. Expects bytes no closer than one
 * PS/2 frame apart and never stalls, so events meeting a full FIFO are lost.
 */

`timescale 1ns/10ps

module scancode_convert (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          enable,
   input  logic                          code_valid,
   input  logic [7:0]                    code,
   input  logic [7:0]                    rom_data,
   input  logic                          full,
   output logic [8:0]                    rom_addr,
   output logic                          push,
   output logic [kbd_pkg::KEYCODE_W-1:0] push_code,
   output logic                          overflow
);

   import kbd_pkg::*;

   conv_state_t state;
   conv_state_t state_ns;
   logic [7:0]  sc;
   logic        e0_flag;
   logic        accept;
   logic        mapped;

   // Disable only blocks new sequences, a started one runs to the end
   assign accept = code_valid & (enable | (state != IDLE));

   ////////////////////////////////////////////////////////////////////////////
   // State machine
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset)
         state <= IDLE;
      else
         state <= state_ns;
   end

   always_comb begin
      state_ns = state;
      case (state)
         IDLE: begin
            if (accept) begin
               if (code == CODE_E0)
                  state_ns = E0;
               else if (code == CODE_F0)
                  state_ns = F0;
               else
                  state_ns = CONVERT_DOWN;
            end
         end
         E0: begin
            if (accept)
               state_ns = (code == CODE_F0) ? E0F0 : CONVERT_DOWN;
         end
         F0, E0F0: begin
            if (accept)
               state_ns = CONVERT_UP;
         end
         CONVERT_DOWN, CONVERT_UP: begin
            state_ns = STROBE;
         end
         STROBE: begin
            state_ns = IDLE;
         end
         default: begin
            state_ns = IDLE;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Byte, prefix flag and keycode
   ////////////////////////////////////////////////////////////////////////////

   // Last accepted byte, prefixes get overwritten by the final byte
   always_ff @(posedge clk) begin
      if (accept)
         sc <= code;
   end

   // E0 flag stays up through STROBE so the ROM address holds
   always_ff @(posedge clk) begin
      if (reset)
         e0_flag <= 1'b0;
      else if (state == IDLE && accept && code == CODE_E0)
         e0_flag <= 1'b1;
      else if (state == STROBE)
         e0_flag <= 1'b0;
   end

   assign rom_addr = {e0_flag, sc};

   // Break flag on top of the translated code
   always_ff @(posedge clk) begin
      if (state == CONVERT_DOWN || state == CONVERT_UP)
         push_code <= {state == CONVERT_UP, rom_data};
   end

   // Zero entry means unmapped, drop it quietly
   assign mapped   = (rom_data != 8'h00);
   assign push     = (state == STROBE) & mapped & ~full;
   assign overflow = (state == STROBE) & mapped & full;

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   // Receiver spacing keeps bytes out of the convert states
   a_code_in_accept: assert property (@(posedge clk) disable iff (reset)
      code_valid |-> state inside {IDLE, E0, F0, E0F0});

   a_push_ovf_excl: assert property (@(posedge clk) disable iff (reset)
      !(push && overflow));

endmodule

// ==== design/key_fifo.sv ====
/*
 * Keycode FIFO, head entry shown combinationally. Flush wins over push and
 * pop. Pushes while full are ignored, the writer flags them itself.
 */

`timescale 1ns/10ps

module key_fifo (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          push,
   input  logic [kbd_pkg::KEYCODE_W-1:0] push_code,
   input  logic                          pop,
   input  logic                          flush,
   output logic [kbd_pkg::KEYCODE_W-1:0] pop_code,
   output logic                          full,
   output logic                          empty,
   output logic [3:0]                    count
);

   import kbd_pkg::*;

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   logic [KEYCODE_W-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0]     wr_ptr;
   logic [PTR_W-1:0]     rd_ptr;
   logic                 wr_en;
   logic                 rd_en;

   assign wr_en = push & ~full;
   assign rd_en = pop & ~empty;

   // Storage
   always_ff @(posedge clk) begin
      if (wr_en && !flush)
         mem[wr_ptr] <= push_code;
   end

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (reset || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= 4'd0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         if (wr_en && !rd_en)
            count <= count + 4'd1;
         else if (rd_en && !wr_en)
            count <= count - 4'd1;
      end
   end

   assign pop_code = mem[rd_ptr];
   assign empty    = (count == 4'd0);
   assign full     = (count == 4'(FIFO_DEPTH));

   a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full);
   a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

// ==== design/kbd_apb_regs.sv ====
/*
 * APB slave with no wait states. Offsets outside STATUS, DATA and CTRL
 * answer with pslverr. Reading DATA pops the FIFO.
 */

`timescale 1ns/10ps

module kbd_apb_regs (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [3:0]                    paddr,
   input  logic [31:0]                   pwdata,
   input  logic                          empty,
   input  logic [3:0]                    count,
   input  logic [kbd_pkg::KEYCODE_W-1:0] pop_code,
   input  logic                          frame_err,
   input  logic                          overflow,
   output logic [31:0]                   prdata,
   output logic                          pready,
   output logic                          pslverr,
   output logic                          enable,
   output logic                          pop,
   output logic                          flush
);

   import kbd_pkg::*;

   kbd_reg_t reg_sel;
   logic     access;
   logic     addr_ok;
   logic     wr_status;
   logic     wr_ctrl;
   logic     ovf_flag;
   logic     err_flag;

   assign reg_sel = kbd_reg_t'(paddr);
   assign access  = psel & penable;
   assign addr_ok = reg_sel inside {REG_STATUS, REG_DATA, REG_CTRL};

   assign pready  = 1'b1;
   assign pslverr = access & ~addr_ok;

   assign wr_status = access & pwrite & (reg_sel == REG_STATUS);
   assign wr_ctrl   = access & pwrite & (reg_sel == REG_CTRL);

   // FIFO strobes
   assign pop   = access & ~pwrite & (reg_sel == REG_DATA) & ~empty;
   assign flush = wr_ctrl & pwdata[1];

   ////////////////////////////////////////////////////////////////////////////
   // Control and sticky flags
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         enable   <= 1'b0;
         ovf_flag <= 1'b0;
         err_flag <= 1'b0;
      end else begin
         if (wr_ctrl)
            enable <= pwdata[0];
         // Set beats W1C in the same cycle
         ovf_flag <= overflow | (ovf_flag & ~(wr_status & pwdata[1]));
         err_flag <= frame_err | (err_flag & ~(wr_status & pwdata[2]));
      end
   end

   // Read mux
   always_comb begin
      prdata = 32'd0;
      if (psel) begin
         case (reg_sel)
            REG_STATUS: prdata = {24'd0, count, 1'b0, err_flag, ovf_flag, ~empty};
            REG_DATA: begin
               if (!empty)
                  prdata = {{(32 - KEYCODE_W){1'b0}}, pop_code};
            end
            REG_CTRL:   prdata = {31'd0, enable};
            default:    prdata = 32'd0;
         endcase
      end
   end

endmodule

// ==== design/kbd_top.sv ====
/*
 * PS/2 keyboard front end with an APB host port.
 * Keyboard lines are asynchronous and are synchronized inside the receiver.
 */

`timescale 1ns/10ps

module kbd_top (
   input  logic        clk,
   input  logic        reset,
   input  logic        ps2_clk,
   input  logic        ps2_data,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [3:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr
);

   import kbd_pkg::*;

   logic                 code_valid;
   logic [7:0]           code;
   logic                 frame_err;
   logic [8:0]           rom_addr;
   logic [7:0]           rom_data;
   logic                 push;
   logic [KEYCODE_W-1:0] push_code;
   logic                 overflow;
   logic                 enable;
   logic                 pop;
   logic                 flush;
   logic [KEYCODE_W-1:0] pop_code;
   logic                 full;
   logic                 empty;
   logic [3:0]           count;

   ps2_rx i_ps2_rx (
      .clk(clk), .reset(reset), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
      .code_valid(code_valid), .code(code), .frame_err(frame_err));

   scancode_convert i_scancode_convert (
      .clk(clk), .reset(reset), .enable(enable), .code_valid(code_valid),
      .code(code), .rom_data(rom_data), .full(full), .rom_addr(rom_addr),
      .push(push), .push_code(push_code), .overflow(overflow));

   scancode_rom i_scancode_rom (.addr(rom_addr), .data(rom_data));

   key_fifo i_key_fifo (
      .clk(clk), .reset(reset), .push(push), .push_code(push_code), .pop(pop),
      .flush(flush), .pop_code(pop_code), .full(full), .empty(empty), .count(count));

   kbd_apb_regs i_kbd_apb_regs (
      .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .empty(empty), .count(count),
      .pop_code(pop_code), .frame_err(frame_err), .overflow(overflow),
      .prdata(prdata), .pready(pready), .pslverr(pslverr), .enable(enable),
      .pop(pop), .flush(flush));

endmodule

// ==== sim/kbd_tb_tasks.svh ====
/*
 * PS/2 and APB stimulus plus the directed tests, included inside kbd_tb.
 * Every drive happens on the falling edge of clk.
 */

`ifndef KBD_TB_TASKS_SVH
`define KBD_TB_TASKS_SVH

// One keyboard frame, data changes while ps2_clk is high
task automatic ps2_send(input logic [7:0] data, input bit bad_parity);
   logic [10:0] frame;
   // Stop, odd parity, data LSB first, start
   frame = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};
   @(negedge clk);
   for (int i = 0; i < 11; i++) begin
      ps2_data = frame[i];
      repeat (HALF_BIT) @(negedge clk);
      ps2_clk = 1'b0;
      repeat (HALF_BIT) @(negedge clk);
      ps2_clk = 1'b1;
   end
   ps2_data = 1'b1;
   repeat (FRAME_GAP) @(negedge clk);
endtask

// Bit 8 of scan asks for the E0 prefix
task automatic send_key(input logic [8:0] scan, input bit brk);
   if (scan[8])
      ps2_send(CODE_E0, 1'b0);
   if (brk)
      ps2_send(CODE_F0, 1'b0);
   ps2_send(scan[7:0], 1'b0);
endtask

task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
   @(negedge clk);
   psel    = 1'b1;
   penable = 1'b0;
   pwrite  = 1'b1;
   paddr   = addr;
   pwdata  = data;
   @(negedge clk);
   penable = 1'b1;
   // Sample mid access phase, before the completing edge
   #(CLK_PERIOD / 4);
   err = pslverr;
   // No wait states, so the access ends on this edge
   check_equal("apb_write_pready", 32'h1, {31'd0, pready});
   @(negedge clk);
   psel    = 1'b0;
   penable = 1'b0;
   pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
   @(negedge clk);
   psel    = 1'b1;
   penable = 1'b0;
   pwrite  = 1'b0;
   paddr   = addr;
   @(negedge clk);
   penable = 1'b1;
   #(CLK_PERIOD / 4);
   data = prdata;
   err  = pslverr;
   check_equal("apb_read_pready", 32'h1, {31'd0, pready});
   @(negedge clk);
   psel    = 1'b0;
   penable = 1'b0;
endtask

task automatic read_expect(input string test, input logic [3:0] addr,
                           input logic [31:0] expected);
   logic [31:0] data;
   logic        err;
   apb_read(addr, data, err);
   check_equal({test, "_slverr"}, 32'h0, err);
   check_equal(test, expected, data);
endtask

// Directed tests

task automatic test_reset_decode();
   logic [31:0] data;
   logic        err;
   read_expect("reset_status", REG_STATUS, 32'h0);
   read_expect("reset_data", REG_DATA, 32'h0);
   read_expect("reset_ctrl", REG_CTRL, 32'h0);
   // Offset 0xC is outside the map
   apb_read(4'hC, data, err);
   check_equal("decode_read_slverr", 32'h1, err);
   apb_write(4'hC, 32'h1, err);
   check_equal("decode_write_slverr", 32'h1, err);
endtask

task automatic test_plain_keys();
   logic err;
   int   idx;
   apb_write(REG_CTRL, 32'h1, err);
   send_key(9'h01C, 1'b0);
   send_key(9'h01C, 1'b1);
   read_expect("plain_make", REG_DATA, 32'h023);
   read_expect("plain_break", REG_DATA, 32'h123);
   read_expect("plain_empty", REG_DATA, 32'h0);
   idx = $urandom % 4;
   send_key(table_scancode(idx), 1'b0);
   send_key(table_scancode(idx), 1'b1);
   read_expect("random_make", REG_DATA, {24'd0, table_keycode(idx)});
   read_expect("random_break", REG_DATA, {23'd0, 1'b1, table_keycode(idx)});
   read_expect("random_empty", REG_DATA, 32'h0);
endtask

task automatic test_extended_keys();
   send_key(9'h175, 1'b0);
   send_key(9'h175, 1'b1);
   // Same byte without E0 has no entry
   send_key(9'h075, 1'b0);
   read_expect("ext_make", REG_DATA, 32'h06B);
   read_expect("ext_break", REG_DATA, 32'h16B);
   read_expect("ext_plain_unmapped", REG_DATA, 32'h0);
endtask

task automatic test_errors_drops();
   logic err;
   ps2_send(8'h1C, 1'b1);
   read_expect("parity_status", REG_STATUS, 32'h4);
   read_expect("parity_data", REG_DATA, 32'h0);
   apb_write(REG_STATUS, 32'h4, err);
   read_expect("parity_clear", REG_STATUS, 32'h0);
   send_key(9'h00F, 1'b0);
   read_expect("unmapped_status", REG_STATUS, 32'h0);
   apb_write(REG_CTRL, 32'h0, err);
   send_key(9'h01C, 1'b0);
   send_key(9'h01C, 1'b1);
   read_expect("disabled_status", REG_STATUS, 32'h0);
   apb_write(REG_CTRL, 32'h1, err);
endtask

task automatic test_overflow_flush();
   logic [7:0] expected_codes [FIFO_DEPTH];
   logic       err;
   int         idx;
   // Ninth make finds the FIFO full
   for (int n = 0; n < FIFO_DEPTH + 1; n++) begin
      idx = $urandom % 7;
      send_key(table_scancode(idx), 1'b0);
      if (n < FIFO_DEPTH)
         expected_codes[n] = table_keycode(idx);
   end
   read_expect("overflow_status", REG_STATUS, 32'h83);
   for (int n = 0; n < FIFO_DEPTH; n++)
      read_expect($sformatf("overflow_read%0d", n), REG_DATA, {24'd0, expected_codes[n]});
   apb_write(REG_STATUS, 32'h2, err);
   read_expect("overflow_clear", REG_STATUS, 32'h0);
   for (int n = 0; n < 3; n++)
      send_key(table_scancode($urandom % 7), 1'b0);
   read_expect("refill_status", REG_STATUS, 32'h31);
   // Flush with enable kept set
   apb_write(REG_CTRL, 32'h3, err);
   read_expect("flush_status", REG_STATUS, 32'h0);
   read_expect("flush_ctrl", REG_CTRL, 32'h1);
endtask

`endif

// ==== sim/kbd_tb.sv ====
/*
 * Directed testbench for the PS/2 keyboard front end. The keyboard clock runs
 * at 8 clk cycles per bit, far faster than a real keyboard, to keep runs short.
 */

`timescale 1ns/10ps

module kbd_tb;

   import kbd_pkg::*;

   localparam int CLK_PERIOD = 100;
   // Half a PS/2 bit, in clk cycles
   localparam int HALF_BIT = 4;
   // Idle after a frame, covers sync, receiver and converter latency
   localparam int FRAME_GAP = 6;
   // About 40 frames of roughly 100 cycles each, with a wide margin
   localparam int TIMEOUT_CYCLES = 20000;

   logic        clk;
   logic        reset;
   logic        ps2_clk;
   logic        ps2_data;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [3:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   int          cycle_count = 0;

   kbd_top i_kbd_top (
      .clk(clk), .reset(reset), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
      .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr));

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Failure reporting and checks
   ////////////////////////////////////////////////////////////////////////////

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_equal(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else
         stop_with_failure($sformatf("mismatch %s expected 0x%0h actual 0x%0h",
                                     test, expected, actual));
   endtask

   // Reference key table
   // Index 0..3 plain keys, 4..6 extended keys
   function automatic logic [8:0] table_scancode(input int idx);
      case (idx)
         0: table_scancode = 9'h01C;
         1: table_scancode = 9'h032;
         2: table_scancode = 9'h05A;
         3: table_scancode = 9'h029;
         4: table_scancode = 9'h175;
         5: table_scancode = 9'h172;
         default: table_scancode = 9'h114;
      endcase
   endfunction

   function automatic logic [7:0] table_keycode(input int idx);
      case (idx)
         0: table_keycode = 8'h23;
         1: table_keycode = 8'h3C;
         2: table_keycode = 8'h36;
         3: table_keycode = 8'h13;
         4: table_keycode = 8'h6B;
         5: table_keycode = 8'h6C;
         default: table_keycode = 8'h7A;
      endcase
   endfunction

   `include "kbd_tb_tasks.svh"

   // Run limit
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
         stop_with_failure($sformatf("timeout, the tests did not finish in %0d cycles",
                                     TIMEOUT_CYCLES));
   end

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      // Lines idle high, bus idle
      reset    = 1'b1;
      ps2_clk  = 1'b1;
      ps2_data = 1'b1;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = 4'h0;
      pwdata   = 32'h0;
      void'($urandom(78));
      // Three rising edges in reset, release on a falling edge
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      test_reset_decode();
      test_plain_keys();
      test_extended_keys();
      test_errors_drops();
      test_overflow_flush();

      $display("Testbench passed");
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+sim
design/kbd_pkg.sv
design/ps2_rx.sv
design/scancode_rom.sv
design/scancode_convert.sv
design/key_fifo.sv
design/kbd_apb_regs.sv
design/kbd_top.sv
sim/kbd_tb.sv
